// ==== build.f ====
common/circle_pkg.sv
hw/circle_ctrl.sv
hw/circle_datapath.sv
hw/fillscreen.sv
hw/pixel_select.sv
hw/circle_top.sv
tests/circle_tb.sv

// ==== common/circle_pkg.sv ====
package circle_pkg;

    // Controller sequence for one clear-and-draw run
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        FILL  = 3'd1,
        INIT  = 3'd2,
        CHECK = 3'd3,
        PLOT  = 3'd4,
        STEP  = 3'd5,
        DONE  = 3'd6
    } ctrl_state_t;

    // One of the eight symmetric circle points per iteration
    typedef enum logic [2:0] {
        OCT_0 = 3'd0,
        OCT_1 = 3'd1,
        OCT_2 = 3'd2,
        OCT_3 = 3'd3,
        OCT_4 = 3'd4,
        OCT_5 = 3'd5,
        OCT_6 = 3'd6,
        OCT_7 = 3'd7
    } octant_t;

    // Default frame buffer geometry
    localparam int SCREEN_W_DEFAULT = 160;
    localparam int SCREEN_H_DEFAULT = 120;

    // Pixel coordinate widths that cover the default screen
    localparam int VGA_X_DW_DEFAULT = 8;
    localparam int VGA_Y_DW_DEFAULT = 7;

    // 3-bit RGB colour
    localparam int COLOUR_W = 3;

endpackage

// ==== hw/circle_ctrl.sv ====
`timescale 1ns/1ps

module circle_ctrl #(
    parameter int OFFSET_DW = 9
)(
    input  logic                        clk,
    input  logic                        resetn,

    input  logic                        start,
    input  logic                        fill_done,
    input  logic signed [OFFSET_DW-1:0] offset_x,
    input  logic signed [OFFSET_DW-1:0] offset_y,

    output logic                        fill_start,
    output logic                        load_init,
    output logic                        step,
    output logic                        draw_circle,
    output logic                        circle_plot_en,
    output circle_pkg::octant_t         octant_sel,
    output logic                        done
);

    circle_pkg::ctrl_state_t state;
    circle_pkg::ctrl_state_t state_next;
    circle_pkg::octant_t     oct_cnt;
    logic                    loop_ok;
    logic                    start_ok;

    // Midpoint loop keeps running while y has not passed x
    assign loop_ok = (offset_y <= offset_x);

    // Start is only honoured when no run is in progress
    assign start_ok = start &&
                      (state == circle_pkg::IDLE || state == circle_pkg::DONE);

    always_comb begin
        state_next = state;
        case (state)
            circle_pkg::IDLE: begin
                if (start_ok) begin
                    state_next = circle_pkg::FILL;
                end
            end
            circle_pkg::FILL: begin
                if (fill_done) begin
                    state_next = circle_pkg::INIT;
                end
            end
            circle_pkg::INIT: begin
                state_next = circle_pkg::CHECK;
            end
            circle_pkg::CHECK: begin
                if (loop_ok) begin
                    state_next = circle_pkg::PLOT;
                end else begin
                    state_next = circle_pkg::DONE;
                end
            end
            circle_pkg::PLOT: begin
                // Eight cycles, one per octant
                if (oct_cnt == circle_pkg::OCT_7) begin
                    state_next = circle_pkg::STEP;
                end
            end
            circle_pkg::STEP: begin
                state_next = circle_pkg::CHECK;
            end
            circle_pkg::DONE: begin
                if (start_ok) begin
                    state_next = circle_pkg::FILL;
                end
            end
            default: begin
                state_next = circle_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= circle_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Octant counter restarts at OCT_0 on every entry to PLOT
    always_ff @(posedge clk) begin
        if (!resetn) begin
            oct_cnt <= circle_pkg::OCT_0;
        end else if (state == circle_pkg::CHECK) begin
            oct_cnt <= circle_pkg::OCT_0;
        end else if (state == circle_pkg::PLOT) begin
            oct_cnt <= circle_pkg::octant_t'(oct_cnt + 3'd1);
        end
    end

    // Strobes decoded straight from the state
    assign fill_start     = start_ok;
    assign load_init      = (state == circle_pkg::INIT);
    assign step           = (state == circle_pkg::STEP);
    assign circle_plot_en = (state == circle_pkg::PLOT);
    assign done           = (state == circle_pkg::DONE);
    assign octant_sel     = oct_cnt;

    // Circle source owns the pixel port from INIT onwards
    assign draw_circle = (state == circle_pkg::INIT)  ||
                         (state == circle_pkg::CHECK) ||
                         (state == circle_pkg::PLOT)  ||
                         (state == circle_pkg::STEP)  ||
                         (state == circle_pkg::DONE);

endmodule

// ==== hw/circle_datapath.sv ====
`timescale 1ns/1ps

module circle_datapath #(
    parameter int RADIUS_DW = 8,
    parameter int OFFSET_DW = 9
)(
    input  logic                        clk,
    input  logic                        resetn,

    input  logic [RADIUS_DW-1:0]        radius,
    input  logic                        load_init,
    input  logic                        step,

    output logic signed [OFFSET_DW-1:0] offset_x,
    output logic signed [OFFSET_DW-1:0] offset_y
);

    // Two spare bits so that 2*(y-x)+1 never wraps
    localparam int CRIT_DW = OFFSET_DW + 2;

    localparam logic signed [CRIT_DW-1:0] CRIT_ONE = 1;

    logic signed [CRIT_DW-1:0]   crit;
    logic signed [CRIT_DW-1:0]   crit_next;
    logic signed [CRIT_DW-1:0]   radius_ext;
    logic signed [CRIT_DW-1:0]   y_ext;
    logic signed [CRIT_DW-1:0]   x_ext;
    logic signed [OFFSET_DW-1:0] x_next;
    logic signed [OFFSET_DW-1:0] y_next;
    logic                        dec_x;

    // Radius is unsigned, so zero extend it
    assign radius_ext = {{(CRIT_DW-RADIUS_DW){1'b0}}, radius};

    // x only moves in when the criterion has gone positive
    assign dec_x  = (crit > 0);
    assign y_next = offset_y + 1'b1;
    assign x_next = dec_x ? (offset_x - 1'b1) : offset_x;

    always_comb begin
        y_ext = y_next;
        x_ext = x_next;
        if (dec_x) begin
            crit_next = crit + ((y_ext - x_ext) <<< 1) + CRIT_ONE;
        end else begin
            crit_next = crit + (y_ext <<< 1) + CRIT_ONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            offset_x <= '0;
            offset_y <= '0;
            crit     <= '0;
        end else if (load_init) begin
            offset_x <= OFFSET_DW'(radius);
            offset_y <= '0;
            crit     <= CRIT_ONE - radius_ext;
        end else if (step) begin
            offset_x <= x_next;
            offset_y <= y_next;
            crit     <= crit_next;
        end
    end

endmodule

// ==== hw/circle_top.sv ====
`timescale 1ns/1ps

module circle_top #(
    parameter int SCREEN_W  = circle_pkg::SCREEN_W_DEFAULT,
    parameter int SCREEN_H  = circle_pkg::SCREEN_H_DEFAULT,
    parameter int VGA_X_DW  = circle_pkg::VGA_X_DW_DEFAULT,
    parameter int VGA_Y_DW  = circle_pkg::VGA_Y_DW_DEFAULT,
    parameter int RADIUS_DW = 8,
    parameter int OFFSET_DW = VGA_X_DW + 1
)(
    input  logic                            clk,
    input  logic                            resetn,

    input  logic                            start,
    input  logic [RADIUS_DW-1:0]            radius,
    input  logic [VGA_X_DW-1:0]             centre_x,
    input  logic [VGA_Y_DW-1:0]             centre_y,
    input  logic [circle_pkg::COLOUR_W-1:0] colour,

    output logic [VGA_X_DW-1:0]             vga_x,
    output logic [VGA_Y_DW-1:0]             vga_y,
    output logic [circle_pkg::COLOUR_W-1:0] vga_colour,
    output logic                            plot,
    output logic                            done
);

    logic                        fill_start;
    logic                        fill_done;
    logic                        load_init;
    logic                        step;
    logic                        draw_circle;
    logic                        circle_plot_en;
    circle_pkg::octant_t         octant_sel;
    logic signed [OFFSET_DW-1:0] offset_x;
    logic signed [OFFSET_DW-1:0] offset_y;
    logic [VGA_X_DW-1:0]         fill_x;
    logic [VGA_Y_DW-1:0]         fill_y;
    logic                        fill_plot;

    circle_ctrl #(
        .OFFSET_DW (OFFSET_DW)
    ) i_ctrl (
        .clk            (clk),
        .resetn         (resetn),
        .start          (start),
        .fill_done      (fill_done),
        .offset_x       (offset_x),
        .offset_y       (offset_y),
        .fill_start     (fill_start),
        .load_init      (load_init),
        .step           (step),
        .draw_circle    (draw_circle),
        .circle_plot_en (circle_plot_en),
        .octant_sel     (octant_sel),
        .done           (done)
    );

    circle_datapath #(
        .RADIUS_DW (RADIUS_DW),
        .OFFSET_DW (OFFSET_DW)
    ) i_datapath (
        .clk       (clk),
        .resetn    (resetn),
        .radius    (radius),
        .load_init (load_init),
        .step      (step),
        .offset_x  (offset_x),
        .offset_y  (offset_y)
    );

    fillscreen #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H),
        .VGA_X_DW (VGA_X_DW),
        .VGA_Y_DW (VGA_Y_DW)
    ) i_fill (
        .clk        (clk),
        .resetn     (resetn),
        .fill_start (fill_start),
        .fill_done  (fill_done),
        .fill_x     (fill_x),
        .fill_y     (fill_y),
        .fill_plot  (fill_plot)
    );

    pixel_select #(
        .SCREEN_W  (SCREEN_W),
        .SCREEN_H  (SCREEN_H),
        .VGA_X_DW  (VGA_X_DW),
        .VGA_Y_DW  (VGA_Y_DW),
        .OFFSET_DW (OFFSET_DW)
    ) i_pixel (
        .clk            (clk),
        .resetn         (resetn),
        .centre_x       (centre_x),
        .centre_y       (centre_y),
        .colour         (colour),
        .load_init      (load_init),
        .draw_circle    (draw_circle),
        .circle_plot_en (circle_plot_en),
        .octant_sel     (octant_sel),
        .offset_x       (offset_x),
        .offset_y       (offset_y),
        .fill_x         (fill_x),
        .fill_y         (fill_y),
        .fill_plot      (fill_plot),
        .vga_x          (vga_x),
        .vga_y          (vga_y),
        .vga_colour     (vga_colour),
        .plot           (plot)
    );

endmodule

// ==== hw/fillscreen.sv ====
`timescale 1ns/1ps

module fillscreen #(
    parameter int SCREEN_W = 160,
    parameter int SCREEN_H = 120,
    parameter int VGA_X_DW = 8,
    parameter int VGA_Y_DW = 7
)(
    input  logic                clk,
    input  logic                resetn,

    input  logic                fill_start,
    output logic                fill_done,
    output logic [VGA_X_DW-1:0] fill_x,
    output logic [VGA_Y_DW-1:0] fill_y,
    output logic                fill_plot
);

    localparam logic [VGA_X_DW-1:0] X_LAST = VGA_X_DW'(SCREEN_W - 1);
    localparam logic [VGA_Y_DW-1:0] Y_LAST = VGA_Y_DW'(SCREEN_H - 1);

    logic busy;

    // Column-major raster, y is the inner loop
    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy      <= 1'b0;
            fill_done <= 1'b0;
            fill_x    <= '0;
            fill_y    <= '0;
        end else if (fill_start) begin
            busy      <= 1'b1;
            fill_done <= 1'b0;
            fill_x    <= '0;
            fill_y    <= '0;
        end else if (busy) begin
            if (fill_y == Y_LAST) begin
                fill_y <= '0;
                if (fill_x == X_LAST) begin
                    busy      <= 1'b0;
                    fill_done <= 1'b1;
                end else begin
                    fill_x <= fill_x + 1'b1;
                end
            end else begin
                fill_y <= fill_y + 1'b1;
            end
        end
    end

    assign fill_plot = busy;

endmodule

// ==== hw/pixel_select.sv ====
`timescale 1ns/1ps

module pixel_select #(
    parameter int SCREEN_W  = 160,
    parameter int SCREEN_H  = 120,
    parameter int VGA_X_DW  = 8,
    parameter int VGA_Y_DW  = 7,
    parameter int OFFSET_DW = 9
)(
    input  logic                            clk,
    input  logic                            resetn,

    input  logic [VGA_X_DW-1:0]             centre_x,
    input  logic [VGA_Y_DW-1:0]             centre_y,
    input  logic [circle_pkg::COLOUR_W-1:0] colour,
    input  logic                            load_init,
    input  logic                            draw_circle,
    input  logic                            circle_plot_en,
    input  circle_pkg::octant_t             octant_sel,
    input  logic signed [OFFSET_DW-1:0]     offset_x,
    input  logic signed [OFFSET_DW-1:0]     offset_y,
    input  logic [VGA_X_DW-1:0]             fill_x,
    input  logic [VGA_Y_DW-1:0]             fill_y,
    input  logic                            fill_plot,

    output logic [VGA_X_DW-1:0]             vga_x,
    output logic [VGA_Y_DW-1:0]             vga_y,
    output logic [circle_pkg::COLOUR_W-1:0] vga_colour,
    output logic                            plot
);

    // One extra bit over the offsets holds centre plus or minus offset
    localparam int PT_DW = OFFSET_DW + 1;

    logic [VGA_X_DW-1:0]             cx_q;
    logic [VGA_Y_DW-1:0]             cy_q;
    logic [circle_pkg::COLOUR_W-1:0] colour_q;
    logic signed [PT_DW-1:0]         cx_ext;
    logic signed [PT_DW-1:0]         cy_ext;
    logic signed [PT_DW-1:0]         dx;
    logic signed [PT_DW-1:0]         dy;
    logic signed [PT_DW-1:0]         pt_x;
    logic signed [PT_DW-1:0]         pt_y;
    logic                            swap;
    logic                            neg_x;
    logic                            neg_y;
    logic                            on_screen;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cx_q     <= '0;
            cy_q     <= '0;
            colour_q <= '0;
        end else if (load_init) begin
            cx_q     <= centre_x;
            cy_q     <= centre_y;
            colour_q <= colour;
        end
    end

    assign cx_ext = {{(PT_DW-VGA_X_DW){1'b0}}, cx_q};
    assign cy_ext = {{(PT_DW-VGA_Y_DW){1'b0}}, cy_q};

    // Swap and sign pattern for each octant
    always_comb begin
        case (octant_sel)
            circle_pkg::OCT_0: {swap, neg_x, neg_y} = 3'b000;
            circle_pkg::OCT_1: {swap, neg_x, neg_y} = 3'b100;
            circle_pkg::OCT_2: {swap, neg_x, neg_y} = 3'b110;
            circle_pkg::OCT_3: {swap, neg_x, neg_y} = 3'b010;
            circle_pkg::OCT_4: {swap, neg_x, neg_y} = 3'b011;
            circle_pkg::OCT_5: {swap, neg_x, neg_y} = 3'b111;
            circle_pkg::OCT_6: {swap, neg_x, neg_y} = 3'b101;
            circle_pkg::OCT_7: {swap, neg_x, neg_y} = 3'b001;
            default:           {swap, neg_x, neg_y} = 3'b000;
        endcase
    end

    always_comb begin
        dx   = swap ? offset_y : offset_x;
        dy   = swap ? offset_x : offset_y;
        pt_x = neg_x ? (cx_ext - dx) : (cx_ext + dx);
        pt_y = neg_y ? (cy_ext - dy) : (cy_ext + dy);
    end

    assign on_screen = (pt_x >= 0) && (pt_x < SCREEN_W) &&
                       (pt_y >= 0) && (pt_y < SCREEN_H);

    // Off-screen points come out at the origin with plot low
    assign vga_x = !draw_circle ? fill_x :
                   on_screen    ? pt_x[VGA_X_DW-1:0] : '0;
    assign vga_y = !draw_circle ? fill_y :
                   on_screen    ? pt_y[VGA_Y_DW-1:0] : '0;

    assign vga_colour = draw_circle ? colour_q : '0;
    assign plot       = draw_circle ? (circle_plot_en && on_screen) : fill_plot;

endmodule

// ==== tests/circle_stim.txt ====
# radius centre_x centre_y colour expected_on_screen_circle_plots
# decimal fields, one test per line, each test starts from the previous DONE
10 80 60 2 64
0 80 60 7 8
1 80 60 5 16
10 0 0 4 18
10 159 119 1 18
10 0 60 6 34
200 80 60 3 0
0 159 119 2 8
0 0 0 1 8

// ==== tests/circle_tb.sv ====
`timescale 1ns/1ps

module circle_tb;

    localparam int SCREEN_W = circle_pkg::SCREEN_W_DEFAULT;
    localparam int SCREEN_H = circle_pkg::SCREEN_H_DEFAULT;
    localparam int X_DW     = circle_pkg::VGA_X_DW_DEFAULT;
    localparam int Y_DW     = circle_pkg::VGA_Y_DW_DEFAULT;
    localparam int C_DW     = circle_pkg::COLOUR_W;

    localparam int PIXEL_TIMEOUT  = 16;
    localparam int CIRCLE_TIMEOUT = 4000;

    // Octant k uses bit k of each mask, order 0..7 as plotted by the DUT
    localparam logic [7:0] SWAP_MASK  = 8'b0110_0110;
    localparam logic [7:0] NEG_X_MASK = 8'b0011_1100;
    localparam logic [7:0] NEG_Y_MASK = 8'b1111_0000;

    logic            clk;
    logic            resetn;
    logic            start;
    logic [7:0]      radius;
    logic [X_DW-1:0] centre_x;
    logic [Y_DW-1:0] centre_y;
    logic [C_DW-1:0] colour;
    logic [X_DW-1:0] vga_x;
    logic [Y_DW-1:0] vga_y;
    logic [C_DW-1:0] vga_colour;
    logic            plot;
    logic            done;

    integer seed;
    int     cyc;
    int     pulse_at;
    int     inject_at;
    int     exp_x_q[$];
    int     exp_y_q[$];

    circle_top i_dut (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .radius     (radius),
        .centre_x   (centre_x),
        .centre_y   (centre_y),
        .colour     (colour),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .plot       (plot),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic raise_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // Drive start just after the edge, then sample at the falling edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        start = (cyc == pulse_at) || (cyc == inject_at);
        cyc = cyc + 1;
        @(negedge clk);
    endtask

    task automatic check_pixel(input string name, input logic [X_DW-1:0] exp_x,
                               input logic [Y_DW-1:0] exp_y, input logic [C_DW-1:0] exp_c);
        if (vga_x !== exp_x || vga_y !== exp_y || vga_colour !== exp_c) begin
            raise_failure($sformatf(
                "[ERROR] %s: expected (%0d,%0d) colour %0d, actual (%0d,%0d) colour %0d",
                name, exp_x, exp_y, exp_c, vga_x, vga_y, vga_colour));
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        if (exp_n != act_n) begin
            raise_failure($sformatf("[ERROR] %s: expected %0d circle plots, actual %0d",
                                    name, exp_n, act_n));
        end
    endtask

    task automatic check_done(input string name, input bit exp_d);
        if (done !== exp_d) begin
            raise_failure($sformatf("[ERROR] %s: expected done %0b, actual %0b",
                                    name, exp_d, done));
        end
    endtask

    task automatic check_plot(input string name, input bit exp_p);
        if (plot !== exp_p) begin
            raise_failure($sformatf("[ERROR] %s: expected plot %0b, actual %0b",
                                    name, exp_p, plot));
        end
    endtask

    task automatic wait_plot(input string name);
        int t;
        t = 0;
        next_cycle();
        while (!plot) begin
            if (t == PIXEL_TIMEOUT) begin
                raise_failure($sformatf("Timeout in %s: no pixel was plotted, controller in %s",
                                        name, i_dut.i_ctrl.state.name()));
            end
            next_cycle();
            t++;
        end
    endtask

    // Midpoint circle recurrence, keeping only the points that land on screen
    task automatic build_expected(input int r, input int cx, input int cy);
        int x;
        int y;
        int crit;
        int k;
        int dx;
        int dy;
        int px;
        int py;
        exp_x_q.delete();
        exp_y_q.delete();
        x = r;
        y = 0;
        crit = 1 - r;
        while (y <= x) begin
            for (k = 0; k < 8; k++) begin
                dx = SWAP_MASK[k] ? y : x;
                dy = SWAP_MASK[k] ? x : y;
                px = NEG_X_MASK[k] ? (cx - dx) : (cx + dx);
                py = NEG_Y_MASK[k] ? (cy - dy) : (cy + dy);
                if (px >= 0 && px < SCREEN_W && py >= 0 && py < SCREEN_H) begin
                    exp_x_q.push_back(px);
                    exp_y_q.push_back(py);
                end
            end
            y = y + 1;
            if (crit <= 0) begin
                crit = crit + 2 * y + 1;
            end else begin
                x = x - 1;
                crit = crit + 2 * (y - x) + 1;
            end
        end
    endtask

    task automatic run_test(input string name, input int r, input int cx, input int cy,
                            input int col, input int exp_count);
        int k;
        int t;
        int got;
        @(posedge clk);
        #1;
        radius   = r[7:0];
        centre_x = cx[X_DW-1:0];
        centre_y = cy[Y_DW-1:0];
        colour   = col[C_DW-1:0];
        @(negedge clk);

        // Real start now, plus one stray start somewhere inside the fill
        pulse_at  = cyc;
        inject_at = pulse_at + 1 + ($unsigned($random(seed)) % (SCREEN_W * SCREEN_H - 1));
        next_cycle();

        for (k = 0; k < SCREEN_W * SCREEN_H; k++) begin
            wait_plot(name);
            check_pixel(name, X_DW'(k / SCREEN_H), Y_DW'(k % SCREEN_H), '0);
            check_done(name, 1'b0);
        end

        build_expected(r, cx, cy);
        check_count({name, " stim count"}, exp_count, exp_x_q.size());

        got = 0;
        t = 0;
        while (!done) begin
            if (t == CIRCLE_TIMEOUT) begin
                raise_failure($sformatf("Timeout in %s: done never rose, controller in %s",
                                        name, i_dut.i_ctrl.state.name()));
            end
            next_cycle();
            t++;
            if (plot) begin
                if (got >= exp_x_q.size()) begin
                    raise_failure($sformatf("%s: more circle pixels were plotted than expected",
                                            name));
                end else begin
                    check_pixel(name, X_DW'(exp_x_q[got]), Y_DW'(exp_y_q[got]), C_DW'(col));
                end
                got++;
            end
        end
        check_count(name, exp_x_q.size(), got);

        // Done holds with the pixel port quiet
        repeat (8) begin
            next_cycle();
            check_done(name, 1'b1);
            check_plot(name, 1'b0);
        end
    endtask

    initial begin
        int fd;
        int code;
        int fields;
        int n;
        int r;
        int cx;
        int cy;
        int col;
        int cnt;
        logic [8*160-1:0] line;
        start     = 1'b0;
        resetn    = 1'b0;
        radius    = '0;
        centre_x  = '0;
        centre_y  = '0;
        colour    = '0;
        seed      = 90;
        cyc       = 0;
        pulse_at  = -1;
        inject_at = -1;

        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;

        repeat (10) begin
            next_cycle();
            check_plot("idle after reset", 1'b0);
            check_done("idle after reset", 1'b0);
        end

        fd = $fopen("tests/circle_stim.txt", "r");
        if (fd == 0) begin
            raise_failure("Could not open tests/circle_stim.txt");
        end
        n = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code != 0) begin
                // Comment lines do not parse as five numbers
                fields = $sscanf(line, "%d %d %d %d %d", r, cx, cy, col, cnt);
                if (fields == 5) begin
                    n++;
                    run_test($sformatf("test %0d (r=%0d at %0d,%0d)", n, r, cx, cy),
                             r, cx, cy, col, cnt);
                end
            end
        end
        $fclose(fd);
        if (n == 0) begin
            raise_failure("No test lines were found in tests/circle_stim.txt");
        end

        $display("All tests passed");
        $finish;
    end

endmodule
